/* Makefile */
TOP = tb_aq32_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/aq32_bus_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

module aq32_bus_decoder (
    input  wire                        clk,
    input  wire                        reset,

    // CPU side
    input  wire aq32_bus_pkg::addr_t   addr,
    input  wire                        wren,
    input  wire                        strobe,

    // Target read data
    input  wire aq32_bus_pkg::data_t   bootrom_rddata,
    input  wire aq32_bus_pkg::half_t   pal_rddata,
    input  wire aq32_bus_pkg::byte_t   chram_rddata,
    input  wire aq32_bus_pkg::half_t   tram_rddata,
    input  wire aq32_bus_pkg::data_t   vram_rddata,
    input  wire aq32_bus_pkg::data_t   sram_rddata,
    input  wire                        sram_wait,
    input  wire aq32_bus_pkg::data_t   regs_rddata,

    // Region strobes
    output logic                       bootrom_sel,
    output logic                       regs_sel,
    output logic                       pal_sel,
    output logic                       chram_sel,
    output logic                       tram_sel,
    output logic                       vram_sel,
    output logic                       sram_sel,

    output logic                       wait_req,
    output aq32_bus_pkg::data_t        rddata
);

    aq32_bus_pkg::addr_t q_addr;  // Address of the previous cycle

    // Upper bits of the address against a region base
    function automatic logic region_hit(aq32_bus_pkg::addr_t a,
                                        aq32_bus_pkg::addr_t base,
                                        int bits);
        return (a >> bits) == (base >> bits);
    endfunction

    //////////////////////////////
    // Region strobes
    //////////////////////////////
    assign bootrom_sel = strobe && region_hit(addr, aq32_bus_pkg::BOOTROM_BASE,
                                              aq32_bus_pkg::PAGE_BITS);
    assign regs_sel    = strobe && region_hit(addr, aq32_bus_pkg::REGS_BASE,
                                              aq32_bus_pkg::PAGE_BITS);
    assign pal_sel     = strobe && region_hit(addr, aq32_bus_pkg::PAL_BASE,
                                              aq32_bus_pkg::PAGE_BITS);
    assign chram_sel   = strobe && region_hit(addr, aq32_bus_pkg::CHRAM_BASE,
                                              aq32_bus_pkg::PAGE_BITS);
    assign tram_sel    = strobe && region_hit(addr, aq32_bus_pkg::TRAM_BASE,
                                              aq32_bus_pkg::PAGE_BITS);
    assign vram_sel    = strobe && region_hit(addr, aq32_bus_pkg::VRAM_BASE,
                                              aq32_bus_pkg::VRAM_BITS);
    assign sram_sel    = strobe && region_hit(addr, aq32_bus_pkg::SRAM_BASE,
                                              aq32_bus_pkg::SRAM_BITS);

    //////////////////////////////
    // Read wait
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_addr <= '0;
        end else begin
            q_addr <= addr;
        end
    end

    // Block RAMs need one cycle for a new read address
    always_comb begin
        wait_req = 1'b0;
        if (bootrom_sel) wait_req = !wren && (q_addr[11:2] != addr[11:2]);  // Word ROM
        if (chram_sel)   wait_req = !wren && (q_addr[11:0] != addr[11:0]);
        if (tram_sel)    wait_req = !wren && (q_addr[11:0] != addr[11:0]);
        if (vram_sel)    wait_req = !wren && (q_addr[14:0] != addr[14:0]);
        if (sram_sel)    wait_req = sram_wait;  // Controller decides
    end

    //////////////////////////////
    // Read data mux
    //////////////////////////////
    always_comb begin
        rddata = '0;  // Unmapped reads as zero
        if (bootrom_sel) rddata = bootrom_rddata;
        if (regs_sel)    rddata = regs_rddata;
        if (pal_sel)     rddata = {2{pal_rddata}};
        if (chram_sel)   rddata = {4{chram_rddata}};
        if (tram_sel)    rddata = {2{tram_rddata}};
        if (vram_sel)    rddata = vram_rddata;
        if (sram_sel)    rddata = sram_rddata;
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({bootrom_sel, regs_sel, pal_sel, chram_sel, tram_sel, vram_sel, sram_sel}));

    // CPU holds the address while waiting, so a block RAM wait lasts one cycle
    a_ram_wait_one: assert property (@(posedge clk) disable iff (reset)
        (wait_req && !sram_sel) |=> !wait_req);

endmodule

`default_nettype wire

/* hdl/aq32_bus_pkg.sv */
`default_nettype none

package aq32_bus_pkg;

    //////////////////////////////
    // CPU bus types
    //////////////////////////////
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] data_t;
    typedef logic  [3:0] bytesel_t;  // Byte lane enables
    typedef logic [15:0] half_t;     // Palette and text RAM word
    typedef logic  [7:0] byte_t;     // Character RAM, keyboard, registers

    //////////////////////////////
    // Address map
    //////////////////////////////
    localparam addr_t BOOTROM_BASE = 32'h0000_0000;  // 4 KB window
    localparam addr_t REGS_BASE    = 32'h0000_2000;
    localparam addr_t PAL_BASE     = 32'h0000_4000;
    localparam addr_t CHRAM_BASE   = 32'h0000_5000;
    localparam addr_t TRAM_BASE    = 32'h0000_6000;
    localparam addr_t VRAM_BASE    = 32'h0000_8000;  // 32 KB window
    localparam addr_t SRAM_BASE    = 32'h0008_0000;  // 512 KB window

    // Low bits left out of the region compare
    localparam int PAGE_BITS = 12;
    localparam int VRAM_BITS = 15;
    localparam int SRAM_BITS = 19;

endpackage

`default_nettype wire

/* hdl/aq32_kbbuf.sv */
`default_nettype none
`timescale 1ns/10ps

module aq32_kbbuf #(
    parameter int ADDR_BITS = 4  // log2 of depth
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       clear,

    input  wire aq32_bus_pkg::byte_t  wrdata,
    input  wire                       wr_en,

    output aq32_bus_pkg::byte_t       rddata,
    input  wire                       rd_en
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    aq32_bus_pkg::byte_t  mem [DEPTH];
    logic [ADDR_BITS-1:0] q_wr_ptr;
    logic [ADDR_BITS-1:0] q_rd_ptr;
    logic [ADDR_BITS:0]   q_count;
    logic                 empty;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign empty = (q_count == '0);
    assign full  = (q_count == DEPTH[ADDR_BITS:0]);
    assign push  = wr_en && !full;   // Dropped when full
    assign pop   = rd_en && !empty;

    assign rddata = empty ? '0 : mem[q_rd_ptr];  // Oldest byte

    always_ff @(posedge clk) begin
        if (push && !clear) begin
            mem[q_wr_ptr] <= wrdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else if (clear) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (push) q_wr_ptr <= q_wr_ptr + 1'b1;
            if (pop)  q_rd_ptr <= q_rd_ptr + 1'b1;
            q_count <= q_count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        q_count <= DEPTH[ADDR_BITS:0]);

endmodule

`default_nettype wire

/* hdl/aq32_periph_top.sv */
`default_nettype none
`timescale 1ns/10ps

module aq32_periph_top #(
    parameter int KBBUF_ADDR_BITS = 4
) (
    input  wire                             clk,
    input  wire                             reset,

    // CPU bus
    input  wire aq32_bus_pkg::addr_t        addr,
    input  wire aq32_bus_pkg::data_t        wrdata,
    input  wire aq32_bus_pkg::bytesel_t     bytesel,  // Memory side only, not used in here
    input  wire                             wren,
    input  wire                             strobe,
    output logic                            wait_req,
    output aq32_bus_pkg::data_t             rddata,

    // Region strobes
    output logic                            bootrom_sel,
    output logic                            regs_sel,
    output logic                            pal_sel,
    output logic                            chram_sel,
    output logic                            tram_sel,
    output logic                            vram_sel,
    output logic                            sram_sel,

    // Memory read data
    input  wire aq32_bus_pkg::data_t        bootrom_rddata,
    input  wire aq32_bus_pkg::half_t        pal_rddata,
    input  wire aq32_bus_pkg::byte_t        chram_rddata,
    input  wire aq32_bus_pkg::half_t        tram_rddata,
    input  wire aq32_bus_pkg::data_t        vram_rddata,
    input  wire aq32_bus_pkg::data_t        sram_rddata,
    input  wire                             sram_wait,

    // ESP32 UART
    input  wire aq32_regs_pkg::uart_data_t  esp_rx_data,
    input  wire                             esp_rx_empty,
    input  wire                             esp_tx_full,
    input  wire                             esp_rx_overflow,
    input  wire                             esp_rx_framing_error,
    output aq32_regs_pkg::uart_data_t       esp_tx_data,
    output logic                            esp_tx_wr,
    output logic                            esp_rx_rd,

    // Keyboard bytes in
    input  wire aq32_bus_pkg::byte_t        kb_data,
    input  wire                             kb_wren,

    // Video engine
    input  wire aq32_regs_pkg::line_t       vline,
    output aq32_regs_pkg::vctrl_t           vctrl,
    output aq32_regs_pkg::scrx_t            vscrx,
    output aq32_regs_pkg::line_t            vscry,
    output aq32_regs_pkg::line_t            virqline
);

    aq32_bus_pkg::data_t regs_rddata;
    aq32_bus_pkg::byte_t kb_rddata;
    logic                kb_pop;
    logic                kb_clear;

    //////////////////////////////
    // Bus decoder
    //////////////////////////////
    aq32_bus_decoder i_decoder (
        .clk            (clk),
        .reset          (reset),
        .addr           (addr),
        .wren           (wren),
        .strobe         (strobe),
        .bootrom_rddata (bootrom_rddata),
        .pal_rddata     (pal_rddata),
        .chram_rddata   (chram_rddata),
        .tram_rddata    (tram_rddata),
        .vram_rddata    (vram_rddata),
        .sram_rddata    (sram_rddata),
        .sram_wait      (sram_wait),
        .regs_rddata    (regs_rddata),
        .bootrom_sel    (bootrom_sel),
        .regs_sel       (regs_sel),
        .pal_sel        (pal_sel),
        .chram_sel      (chram_sel),
        .tram_sel       (tram_sel),
        .vram_sel       (vram_sel),
        .sram_sel       (sram_sel),
        .wait_req       (wait_req),
        .rddata         (rddata)
    );

    //////////////////////////////
    // System registers
    //////////////////////////////
    aq32_sysregs i_sysregs (
        .clk                  (clk),
        .reset                (reset),
        .addr                 (addr),
        .wrdata               (wrdata),
        .wren                 (wren),
        .regs_sel             (regs_sel),
        .regs_rddata          (regs_rddata),
        .vline                (vline),
        .vctrl                (vctrl),
        .vscrx                (vscrx),
        .vscry                (vscry),
        .virqline             (virqline),
        .esp_rx_data          (esp_rx_data),
        .esp_rx_empty         (esp_rx_empty),
        .esp_tx_full          (esp_tx_full),
        .esp_rx_overflow      (esp_rx_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_rx_rd            (esp_rx_rd),
        .kb_rddata            (kb_rddata),
        .kb_pop               (kb_pop),
        .kb_clear             (kb_clear)
    );

    //////////////////////////////
    // Keyboard buffer
    //////////////////////////////
    aq32_kbbuf #(
        .ADDR_BITS (KBBUF_ADDR_BITS)
    ) i_kbbuf (
        .clk    (clk),
        .reset  (reset),
        .clear  (kb_clear),
        .wrdata (kb_data),
        .wr_en  (kb_wren),
        .rddata (kb_rddata),
        .rd_en  (kb_pop)
    );

endmodule

`default_nettype wire

/* hdl/aq32_regs_pkg.sv */
`default_nettype none

package aq32_regs_pkg;

    //////////////////////////////
    // Register word index
    //////////////////////////////
    typedef logic [5:0] reg_idx_t;  // Address bits 7:2

    localparam reg_idx_t REG_ESPCTRL  = 6'd0;  // 0x02000
    localparam reg_idx_t REG_ESPDATA  = 6'd1;  // 0x02004
    localparam reg_idx_t REG_VCTRL    = 6'd2;  // 0x02008
    localparam reg_idx_t REG_VSCRX    = 6'd3;  // 0x0200C
    localparam reg_idx_t REG_VSCRY    = 6'd4;  // 0x02010
    localparam reg_idx_t REG_VLINE    = 6'd5;  // 0x02014
    localparam reg_idx_t REG_VIRQLINE = 6'd6;  // 0x02018
    localparam reg_idx_t REG_KEYBUF   = 6'd7;  // 0x0201C

    //////////////////////////////
    // Register value types
    //////////////////////////////

    // Video control, from bit 7 down:
    // text page, 80 columns, border remap, text priority,
    // sprites enable, graphics mode [2:1], text enable
    typedef logic [7:0] vctrl_t;

    typedef logic [8:0] scrx_t;       // Horizontal scroll
    typedef logic [7:0] line_t;       // Raster line
    typedef logic [8:0] uart_data_t;  // Character plus flag bit

    // ESPCTRL bits, bit 2 reads as 0
    localparam int ESPCTRL_RX_NOT_EMPTY = 0;
    localparam int ESPCTRL_TX_FULL      = 1;
    localparam int ESPCTRL_FRAMING      = 3;
    localparam int ESPCTRL_OVERFLOW     = 4;

endpackage

`default_nettype wire

/* hdl/aq32_sysregs.sv */
`default_nettype none
`timescale 1ns/10ps

module aq32_sysregs (
    input  wire                             clk,
    input  wire                             reset,

    // CPU bus
    input  wire aq32_bus_pkg::addr_t        addr,
    input  wire aq32_bus_pkg::data_t        wrdata,
    input  wire                             wren,
    input  wire                             regs_sel,
    output aq32_bus_pkg::data_t             regs_rddata,

    // Video engine
    input  wire aq32_regs_pkg::line_t       vline,
    output aq32_regs_pkg::vctrl_t           vctrl,
    output aq32_regs_pkg::scrx_t            vscrx,
    output aq32_regs_pkg::line_t            vscry,
    output aq32_regs_pkg::line_t            virqline,

    // ESP32 UART
    input  wire aq32_regs_pkg::uart_data_t  esp_rx_data,
    input  wire                             esp_rx_empty,
    input  wire                             esp_tx_full,
    input  wire                             esp_rx_overflow,
    input  wire                             esp_rx_framing_error,
    output aq32_regs_pkg::uart_data_t       esp_tx_data,
    output logic                            esp_tx_wr,
    output logic                            esp_rx_rd,

    // Keyboard buffer
    input  wire aq32_bus_pkg::byte_t        kb_rddata,
    output logic                            kb_pop,
    output logic                            kb_clear
);

    aq32_regs_pkg::reg_idx_t idx;
    aq32_bus_pkg::byte_t     espctrl;
    logic                    reg_wr;
    logic                    reg_rd;
    logic                    q_overflow;  // Sticky
    logic                    q_framing;   // Sticky

    assign idx    = addr[7:2];
    assign reg_wr = regs_sel && wren;
    assign reg_rd = regs_sel && !wren;

    //////////////////////////////
    // Access strobes
    //////////////////////////////
    assign esp_tx_data = wrdata[8:0];
    assign esp_tx_wr   = reg_wr && (idx == aq32_regs_pkg::REG_ESPDATA);
    assign esp_rx_rd   = reg_rd && (idx == aq32_regs_pkg::REG_ESPDATA);
    assign kb_pop      = reg_rd && (idx == aq32_regs_pkg::REG_KEYBUF);
    assign kb_clear    = reg_wr && (idx == aq32_regs_pkg::REG_KEYBUF);  // Any write empties

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl      <= '0;
            vscrx      <= '0;
            vscry      <= '0;
            virqline   <= '0;
            q_overflow <= 1'b0;
            q_framing  <= 1'b0;
        end else begin
            if (reg_wr) begin
                case (idx)
                    aq32_regs_pkg::REG_ESPCTRL: begin
                        // Write 1 to clear
                        if (wrdata[aq32_regs_pkg::ESPCTRL_OVERFLOW]) q_overflow <= 1'b0;
                        if (wrdata[aq32_regs_pkg::ESPCTRL_FRAMING])  q_framing  <= 1'b0;
                    end
                    aq32_regs_pkg::REG_VCTRL:    vctrl    <= wrdata[7:0];
                    aq32_regs_pkg::REG_VSCRX:    vscrx    <= wrdata[8:0];
                    aq32_regs_pkg::REG_VSCRY:    vscry    <= wrdata[7:0];
                    aq32_regs_pkg::REG_VIRQLINE: virqline <= wrdata[7:0];
                    default: ;
                endcase
            end

            // A new error pulse beats a clear in the same cycle
            if (esp_rx_overflow)      q_overflow <= 1'b1;
            if (esp_rx_framing_error) q_framing  <= 1'b1;
        end
    end

    //////////////////////////////
    // Readback
    //////////////////////////////
    always_comb begin
        espctrl = '0;
        espctrl[aq32_regs_pkg::ESPCTRL_RX_NOT_EMPTY] = !esp_rx_empty;
        espctrl[aq32_regs_pkg::ESPCTRL_TX_FULL]      = esp_tx_full;
        espctrl[aq32_regs_pkg::ESPCTRL_FRAMING]      = q_framing;
        espctrl[aq32_regs_pkg::ESPCTRL_OVERFLOW]     = q_overflow;
    end

    always_comb begin
        regs_rddata = '0;
        case (idx)
            aq32_regs_pkg::REG_ESPCTRL:  regs_rddata = {24'b0, espctrl};
            aq32_regs_pkg::REG_ESPDATA:  regs_rddata = {23'b0, esp_rx_data};
            aq32_regs_pkg::REG_VCTRL:    regs_rddata = {24'b0, vctrl};
            aq32_regs_pkg::REG_VSCRX:    regs_rddata = {23'b0, vscrx};
            aq32_regs_pkg::REG_VSCRY:    regs_rddata = {24'b0, vscry};
            aq32_regs_pkg::REG_VLINE:    regs_rddata = {24'b0, vline};
            aq32_regs_pkg::REG_VIRQLINE: regs_rddata = {24'b0, virqline};
            aq32_regs_pkg::REG_KEYBUF:   regs_rddata = {24'b0, kb_rddata};
            default:                     regs_rddata = '0;
        endcase
    end

    a_uart_excl: assert property (@(posedge clk) disable iff (reset)
        !(esp_tx_wr && esp_rx_rd));

endmodule

`default_nettype wire

/* tests/tb_aq32_periph.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_aq32_periph;

    localparam int NUM_RAND   = 200;
    localparam int NUM_ACCESS = NUM_RAND + 120;  // Random plus directed accesses

    logic clk = 1'b0;
    logic reset;

    aq32_bus_pkg::addr_t      addr;
    aq32_bus_pkg::data_t      wrdata;
    aq32_bus_pkg::bytesel_t   bytesel;
    logic                     wren, strobe, wait_req;
    aq32_bus_pkg::data_t      rddata;
    logic                     bootrom_sel, regs_sel, pal_sel, chram_sel;
    logic                     tram_sel, vram_sel, sram_sel;
    aq32_bus_pkg::data_t      bootrom_rddata, vram_rddata, sram_rddata;
    aq32_bus_pkg::half_t      pal_rddata, tram_rddata;
    aq32_bus_pkg::byte_t      chram_rddata;
    logic                     sram_wait;
    aq32_regs_pkg::uart_data_t esp_rx_data, esp_tx_data;
    logic                     esp_rx_empty, esp_tx_full, esp_rx_overflow;
    logic                     esp_rx_framing_error, esp_tx_wr, esp_rx_rd;
    aq32_bus_pkg::byte_t      kb_data;
    logic                     kb_wren;
    aq32_regs_pkg::line_t     vline, vscry, virqline;
    aq32_regs_pkg::vctrl_t    vctrl;
    aq32_regs_pkg::scrx_t     vscrx;

    aq32_periph_top #(.KBBUF_ADDR_BITS(4)) i_dut (.*);

    always #2 clk = ~clk;  // 4 ns period

    //////////////////////////////
    // Reference model state
    //////////////////////////////
    logic [7:0]  m_vctrl, m_vscry, m_virq;
    logic [8:0]  m_vscrx;
    logic        m_ovf, m_frm;
    logic [7:0]  kb_q[$];
    logic [31:0] prev_addr;     // Address of the previous cycle
    logic        pend_ovf, pend_frm;
    logic [31:0] lfsr = 32'h7f70_5a86;

    // Expected values handed to the compare process
    string       tname;
    logic        chk_en, chk_rd;
    logic [6:0]  exp_sel;
    logic        exp_wait, exp_txwr, exp_rxrd;
    logic [31:0] exp_rd, exp_txdata;
    int          errors, checks;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Region index: 0 ROM, 1 regs, 2 palette, 3 char, 4 text, 5 video, 6 SRAM
    function automatic int region_of(logic [31:0] a);
        if (a[31:12] == 20'h00000) return 0;
        if (a[31:12] == 20'h00002) return 1;
        if (a[31:12] == 20'h00004) return 2;
        if (a[31:12] == 20'h00005) return 3;
        if (a[31:12] == 20'h00006) return 4;
        if (a[31:15] == 17'h00001) return 5;
        if (a[31:19] == 13'h0001)  return 6;
        return -1;
    endfunction

    function automatic logic [6:0] ref_sel(logic [31:0] a);
        int r;
        r = region_of(a);
        return (r < 0) ? 7'b0 : (7'b100_0000 >> r);  // ROM is the top bit
    endfunction

    function automatic logic ref_wait(logic [31:0] a, logic we);
        case (region_of(a))
            0: return !we && (a[11:2] != prev_addr[11:2]);
            3, 4: return !we && (a[11:0] != prev_addr[11:0]);
            5: return !we && (a[14:0] != prev_addr[14:0]);
            6: return sram_wait;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] ref_rddata(logic [31:0] a);
        logic [7:0] ctrl;
        ctrl = {3'b0, m_ovf, m_frm, 1'b0, esp_tx_full, !esp_rx_empty};
        case (region_of(a))
            0: return bootrom_rddata;
            2: return {pal_rddata, pal_rddata};
            3: return {4{chram_rddata}};
            4: return {tram_rddata, tram_rddata};
            5: return vram_rddata;
            6: return sram_rddata;
            1: begin
                case (a[7:2])
                    6'd0: return {24'b0, ctrl};
                    6'd1: return {23'b0, esp_rx_data};
                    6'd2: return {24'b0, m_vctrl};
                    6'd3: return {23'b0, m_vscrx};
                    6'd4: return {24'b0, m_vscry};
                    6'd5: return {24'b0, vline};
                    6'd6: return {24'b0, m_virq};
                    6'd7: return (kb_q.size() > 0) ? {24'b0, kb_q[0]} : 32'b0;
                    default: return 32'b0;
                endcase
            end
            default: return 32'b0;
        endcase
    endfunction

    // Model update at the edge that ends an access
    function automatic void apply_edge(logic [31:0] a, logic we, logic [31:0] wd);
        if (region_of(a) == 1 && we) begin
            case (a[7:2])
                6'd0: begin
                    if (wd[4]) m_ovf = 1'b0;
                    if (wd[3]) m_frm = 1'b0;
                end
                6'd2: m_vctrl = wd[7:0];
                6'd3: m_vscrx = wd[8:0];
                6'd4: m_vscry = wd[7:0];
                6'd6: m_virq  = wd[7:0];
                6'd7: kb_q.delete();
                default: ;
            endcase
        end
        if (region_of(a) == 1 && !we && a[7:2] == 6'd7 && kb_q.size() > 0) begin
            void'(kb_q.pop_front());
        end
        if (esp_rx_overflow)      m_ovf = 1'b1;  // Set beats clear
        if (esp_rx_framing_error) m_frm = 1'b1;
    endfunction

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    always @(posedge clk) begin
        if (chk_en) begin
            check({tname, " sel"}, {25'b0, exp_sel}, {25'b0, bootrom_sel, regs_sel,
                  pal_sel, chram_sel, tram_sel, vram_sel, sram_sel});
            check({tname, " wait"}, {31'b0, exp_wait}, {31'b0, wait_req});
            check({tname, " tx_wr"}, {31'b0, exp_txwr}, {31'b0, esp_tx_wr});
            check({tname, " rx_rd"}, {31'b0, exp_rxrd}, {31'b0, esp_rx_rd});
            if (chk_rd) check({tname, " rddata"}, exp_rd, rddata);
            if (exp_txwr) check({tname, " tx_data"}, exp_txdata, {23'b0, esp_tx_data});
        end
    end

    // One CPU access, held while wait_req is high
    task automatic access(string name, logic [31:0] a, logic we, logic [31:0] wd,
                          int sram_cycles);
        int          cyc;
        logic        w;
        logic [31:0] r;
        cyc = 0;
        w = 1'b1;
        while (w) begin
            @(negedge clk);
            addr = a;
            wren = we;
            wrdata = wd;
            strobe = 1'b1;
            kb_wren = 1'b0;
            esp_rx_overflow = pend_ovf;
            esp_rx_framing_error = pend_frm;
            bootrom_rddata = rand_bits(32);
            vram_rddata = rand_bits(32);
            sram_rddata = rand_bits(32);
            r = rand_bits(32);
            pal_rddata = r[15:0];
            tram_rddata = r[31:16];
            r = rand_bits(8);
            chram_rddata = r[7:0];
            sram_wait = (cyc < sram_cycles);
            tname = name;
            exp_sel = ref_sel(a);
            exp_wait = ref_wait(a, we);
            exp_rd = ref_rddata(a);
            chk_rd = !we;
            exp_txwr = we && region_of(a) == 1 && a[7:2] == 6'd1;
            exp_rxrd = !we && region_of(a) == 1 && a[7:2] == 6'd1;
            exp_txdata = {23'b0, wd[8:0]};
            chk_en = 1'b1;
            #1 w = wait_req;
            @(posedge clk);
            prev_addr = a;
            cyc++;
        end
        apply_edge(a, we, wd);
        pend_ovf = 1'b0;
        pend_frm = 1'b0;
    endtask

    // Bus released on the falling edge, outside inputs may change after it
    task automatic bus_idle();
        @(negedge clk);
        strobe = 1'b0;
        chk_en = 1'b0;
        kb_wren = 1'b0;
        esp_rx_overflow = 1'b0;
        esp_rx_framing_error = 1'b0;
    endtask

    task automatic kb_push(logic [7:0] b);
        @(negedge clk);
        strobe = 1'b0;
        chk_en = 1'b0;
        esp_rx_overflow = 1'b0;
        esp_rx_framing_error = 1'b0;
        kb_data = b;
        kb_wren = 1'b1;
        @(posedge clk);
        if (kb_q.size() < 16) kb_q.push_back(b);  // Full buffer drops the byte
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    initial begin
        #(NUM_ACCESS * 8 * 4 + 200);
        $display("Watchdog timeout, the DUT did not finish its accesses in time");
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [31:0] a, r;
        reset = 1'b1;
        addr = '0;
        wrdata = '0;
        bytesel = 4'hf;
        wren = 1'b0;
        strobe = 1'b0;
        bootrom_rddata = '0;
        pal_rddata = '0;
        chram_rddata = '0;
        tram_rddata = '0;
        vram_rddata = '0;
        sram_rddata = '0;
        sram_wait = 1'b0;
        esp_rx_data = '0;
        esp_rx_empty = 1'b1;
        esp_tx_full = 1'b0;
        esp_rx_overflow = 1'b0;
        esp_rx_framing_error = 1'b0;
        kb_data = '0;
        kb_wren = 1'b0;
        vline = '0;
        m_vctrl = '0;
        m_vscrx = '0;
        m_vscry = '0;
        m_virq = '0;
        m_ovf = 1'b0;
        m_frm = 1'b0;
        prev_addr = '0;
        pend_ovf = 1'b0;
        pend_frm = 1'b0;
        chk_en = 1'b0;
        chk_rd = 1'b0;
        errors = 0;
        checks = 0;
        repeat (2) @(posedge clk);
        @(negedge clk) reset = 1'b0;

        // Random decode and read mux
        for (int i = 0; i < NUM_RAND; i++) begin
            r = rand_bits(4);
            a = rand_bits(20);
            case (r % 10)
                0: a = {20'h00000, a[11:0]};
                1: a = {20'h00002, a[11:0]};
                2: a = {20'h00004, a[11:0]};
                3: a = {20'h00005, a[11:0]};
                4: a = {20'h00006, a[11:0]};
                5: a = {17'h00001, a[14:0]};
                6: a = {13'h0001, a[18:0]};
                7: a = {20'h00003, a[11:0]};   // Unmapped page
                8: a = {20'h00007, a[11:0]};
                default: a = {12'h001, a[19:0]};
            endcase
            access("decode", a, 1'b0, 32'h0, int'(r[1:0]) % 3);
        end

        // Wait rule
        access("wait rom new", 32'h0000_0104, 1'b0, 0, 0);
        access("wait rom same", 32'h0000_0104, 1'b0, 0, 0);
        access("wait rom byte", 32'h0000_0106, 1'b0, 0, 0);
        access("wait chram", 32'h0000_5123, 1'b0, 0, 0);
        access("wait chram same", 32'h0000_5123, 1'b0, 0, 0);
        access("wait tram", 32'h0000_6042, 1'b0, 0, 0);
        access("wait vram", 32'h0000_C010, 1'b0, 0, 0);
        access("wait vram write", 32'h0000_C444, 1'b1, 32'h1234, 0);
        access("wait pal", 32'h0000_4010, 1'b0, 0, 0);
        access("wait regs", 32'h0000_2014, 1'b0, 0, 0);
        access("wait sram", 32'h0008_0100, 1'b0, 0, 4);

        // Video registers
        bus_idle();
        vline = 8'h77;
        access("vctrl wr", 32'h0000_2008, 1'b1, 32'hFFFF_FFA5, 0);
        access("vctrl rd", 32'h0000_2008, 1'b0, 0, 0);
        check("vctrl port", {24'b0, m_vctrl}, {24'b0, vctrl});
        access("vscrx wr", 32'h0000_200C, 1'b1, 32'h0000_F3FF, 0);
        access("vscrx rd", 32'h0000_200C, 1'b0, 0, 0);
        check("vscrx port", {23'b0, m_vscrx}, {23'b0, vscrx});
        access("virq wr", 32'h0000_2018, 1'b1, 32'h0000_0142, 0);
        access("vscry wr", 32'h0000_2010, 1'b1, 32'h0000_0299, 0);
        access("vscry rd", 32'h0000_2010, 1'b0, 0, 0);
        check("vscry port", {24'b0, m_vscry}, {24'b0, vscry});
        access("virq rd", 32'h0000_2018, 1'b0, 0, 0);
        check("virq port", {24'b0, m_virq}, {24'b0, virqline});
        access("vline rd", 32'h0000_2014, 1'b0, 0, 0);

        // UART registers
        bus_idle();
        esp_rx_empty = 1'b0;
        esp_tx_full = 1'b1;
        access("espctrl status", 32'h0000_2000, 1'b0, 0, 0);
        pend_ovf = 1'b1;
        access("ovf pulse", 32'h0000_2000, 1'b0, 0, 0);
        access("ovf sticky", 32'h0000_2000, 1'b0, 0, 0);
        access("ovf wr0", 32'h0000_2000, 1'b1, 32'h0000_0008, 0);
        access("ovf kept", 32'h0000_2000, 1'b0, 0, 0);
        access("ovf wr1", 32'h0000_2000, 1'b1, 32'h0000_0010, 0);
        access("ovf cleared", 32'h0000_2000, 1'b0, 0, 0);
        pend_frm = 1'b1;
        access("frm set", 32'h0000_2000, 1'b0, 0, 0);
        pend_frm = 1'b1;
        access("frm set and clr", 32'h0000_2000, 1'b1, 32'h0000_0008, 0);
        access("frm set wins", 32'h0000_2000, 1'b0, 0, 0);
        access("espdata wr", 32'h0000_2004, 1'b1, 32'h0000_1AB5, 0);
        bus_idle();
        esp_rx_data = 9'h1C3;
        access("espdata rd", 32'h0000_2004, 1'b0, 0, 0);

        // Keyboard buffer
        kb_push(8'h41);
        kb_push(8'h42);
        kb_push(8'h43);
        for (int i = 0; i < 4; i++) access("kb order", 32'h0000_201C, 1'b0, 0, 0);
        for (int i = 0; i < 20; i++) kb_push(8'h60 + 8'(i));
        for (int i = 0; i < 17; i++) access("kb full", 32'h0000_201C, 1'b0, 0, 0);
        for (int i = 0; i < 5; i++) kb_push(8'h90 + 8'(i));
        access("kb clear", 32'h0000_201C, 1'b1, 32'h0, 0);
        access("kb cleared", 32'h0000_201C, 1'b0, 0, 0);

        bus_idle();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/aq32_bus_pkg.sv
hdl/aq32_regs_pkg.sv
hdl/aq32_bus_decoder.sv
hdl/aq32_sysregs.sv
hdl/aq32_kbbuf.sv
hdl/aq32_periph_top.sv
tests/tb_aq32_periph.sv
